/* mc_bus_pkg.sv */
`default_nettype none

package mc_bus_pkg;

    localparam int WB_ADR_W  = 14;   // word address, byte address is 16 bits
    localparam int WB_DAT_W  = 32;
    localparam int WB_SEL_W  = WB_DAT_W / 8;
    localparam int CHAR_W    = 8;
    localparam int CON_CNT_W = 5;
    localparam int CON_PTR_W = 4;
    localparam int RAM_ADR_W = 8;

    typedef logic [WB_ADR_W-1:0]  wb_adr_t;
    typedef logic [WB_DAT_W-1:0]  wb_dat_t;
    typedef logic [WB_SEL_W-1:0]  wb_sel_t;
    typedef logic [CHAR_W-1:0]    char_t;
    typedef logic [CON_CNT_W-1:0] fifo_cnt_t;

    localparam int      RAM_DEPTH      = 256;
    localparam wb_adr_t RAM_BASE       = 14'h0400;   // byte 0x1000
    localparam wb_adr_t CON_TX_ADR     = 14'h0010;   // byte 0x0040
    localparam wb_adr_t CON_STAT_ADR   = 14'h0011;   // byte 0x0044
    localparam wb_adr_t CON_POP_ADR    = 14'h0012;   // byte 0x0048
    localparam int      CON_FIFO_DEPTH = 16;

    typedef struct packed {
        wb_adr_t adr;
        wb_dat_t dat;
        wb_sel_t sel;
        logic    we;
        logic    stb;
    } wb_req_t;

    typedef struct packed {
        wb_dat_t dat;
        logic    ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        CON_IDLE,
        CON_RESPOND,    // ack cycle
        CON_SETTLE
    } con_state_t;

endpackage

`default_nettype wire

/* mc_wb_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_wb_ram
    import mc_bus_pkg::*;
    (
        input  wire     clk,
        input  wire     reset,
        input  wb_req_t i_req,
        output wb_rsp_t o_rsp
    );

    wb_dat_t                mem [RAM_DEPTH];
    wb_dat_t                rd_dat;
    logic                   ack;
    logic                   acc;
    logic [RAM_ADR_W-1:0]   idx;

    assign idx = i_req.adr[RAM_ADR_W-1:0];   // upper bits checked by the decoder
    assign acc = i_req.stb && !ack;

    always_ff @(posedge clk) begin
        if (!reset) begin
            ack <= 1'b0;
        end else begin
            ack <= acc;
        end
    end

    // byte lanes written under sel on the ack edge
    always_ff @(posedge clk) begin
        if (acc && i_req.we) begin
            for (int i = 0; i < WB_SEL_W; i++) begin
                if (i_req.sel[i]) begin
                    mem[idx][8*i +: 8] <= i_req.dat[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            rd_dat <= mem[idx];
        end
    end

    assign o_rsp.dat = rd_dat;
    assign o_rsp.ack = ack;

    a_ram_page: assert property (
        @(posedge clk) disable iff (!reset)
        i_req.stb |-> (i_req.adr[WB_ADR_W-1:RAM_ADR_W] == RAM_BASE[WB_ADR_W-1:RAM_ADR_W])
    ) else $error("ram strobed outside its address page");

endmodule

`default_nettype wire

/* mc_console_port.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_console_port
    import mc_bus_pkg::*;
    (
        input  wire     clk,
        input  wire     reset,
        input  wb_req_t i_req,
        output wb_rsp_t o_rsp,
        output logic    o_char_valid,
        output char_t   o_char
    );

    con_state_t             state;
    char_t                  fifo_mem [CON_FIFO_DEPTH];
    logic [CON_PTR_W-1:0]   wr_ptr;
    logic [CON_PTR_W-1:0]   rd_ptr;
    fifo_cnt_t              cnt;
    logic                   ovf;
    wb_dat_t                rd_dat;
    wb_dat_t                rd_next;
    logic                   acc;
    logic                   wr_tx;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign acc     = i_req.stb && (state != CON_RESPOND);
    assign full    = (cnt == fifo_cnt_t'(CON_FIFO_DEPTH));
    assign wr_tx   = acc && i_req.we && (i_req.adr == CON_TX_ADR) && i_req.sel[0];
    assign do_push = wr_tx && !full;
    assign do_pop  = acc && !i_req.we && (i_req.adr == CON_POP_ADR) && (cnt != '0);

    always_comb begin
        rd_next = '0;
        if (!i_req.we && i_req.adr == CON_STAT_ADR) begin
            rd_next[4:0] = cnt;
            rd_next[8]   = ovf;
        end else if (do_pop) begin
            rd_next[7:0] = fifo_mem[rd_ptr];
            rd_next[8]   = 1'b1;   // valid flag
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state        <= CON_IDLE;
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            cnt          <= '0;
            ovf          <= 1'b0;
            o_char_valid <= 1'b0;
        end else begin
            case (state)
                CON_IDLE:    state <= i_req.stb ? CON_RESPOND : CON_IDLE;
                CON_RESPOND: state <= CON_SETTLE;
                CON_SETTLE:  state <= i_req.stb ? CON_RESPOND : CON_IDLE;
                default:     state <= CON_IDLE;
            endcase
            o_char_valid <= wr_tx;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
                cnt    <= cnt + 1'b1;
            end else if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
                cnt    <= cnt - 1'b1;
            end
            if (wr_tx && full) begin
                ovf <= 1'b1;   // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= i_req.dat[7:0];
        end
        if (wr_tx) begin
            o_char <= i_req.dat[7:0];
        end
        if (acc) begin
            rd_dat <= rd_next;
        end
    end

    assign o_rsp.dat = rd_dat;
    assign o_rsp.ack = (state == CON_RESPOND);

    a_cnt_bound: assert property (
        @(posedge clk) disable iff (!reset)
        cnt <= fifo_cnt_t'(CON_FIFO_DEPTH)
    ) else $error("console fifo count above depth");

    // read pointer only moves on a pop of a non-empty fifo
    a_pop_nonempty: assert property (
        @(posedge clk) disable iff (!reset)
        !$stable(rd_ptr) |-> ($past(cnt) != '0) && (cnt == $past(cnt) - 1'b1)
    ) else $error("console pop with empty fifo");

endmodule

`default_nettype wire

/* mc_bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_bus_decoder
    import mc_bus_pkg::*;
    (
        input  wire     clk,
        input  wire     reset,
        input  wb_req_t i_req,
        output wb_rsp_t o_rsp,
        output wb_req_t o_ram_req,
        input  wb_rsp_t i_ram_rsp,
        output wb_req_t o_con_req,
        input  wb_rsp_t i_con_rsp,
        output logic    o_bus_error
    );

    logic is_ram;
    logic is_con;
    logic is_unm;
    logic unm_ack;

    // ram page is picked by the bits above the ram index
    assign is_ram = (i_req.adr[WB_ADR_W-1:RAM_ADR_W] == RAM_BASE[WB_ADR_W-1:RAM_ADR_W]);

    // console registers are one direction each
    assign is_con = ((i_req.adr == CON_TX_ADR) && i_req.we)
                 || ((i_req.adr == CON_STAT_ADR) && !i_req.we)
                 || ((i_req.adr == CON_POP_ADR) && !i_req.we);

    assign is_unm = !is_ram && !is_con;

    always_comb begin
        o_ram_req     = i_req;
        o_ram_req.stb = i_req.stb && is_ram;
        o_con_req     = i_req;
        o_con_req.stb = i_req.stb && is_con;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            unm_ack <= 1'b0;
        end else begin
            unm_ack <= i_req.stb && is_unm && !unm_ack;
        end
    end

    always_comb begin
        if (i_ram_rsp.ack) begin
            o_rsp.dat = i_ram_rsp.dat;
        end else if (i_con_rsp.ack) begin
            o_rsp.dat = i_con_rsp.dat;
        end else begin
            o_rsp.dat = '0;   // unmapped or idle
        end
    end

    assign o_rsp.ack   = i_ram_rsp.ack || i_con_rsp.ack || unm_ack;
    assign o_bus_error = unm_ack;

    // a slave that acks out of turn would corrupt the merged read word
    a_ack_onehot: assert property (
        @(posedge clk) disable iff (!reset)
        $onehot0({i_ram_rsp.ack, i_con_rsp.ack, unm_ack})
    ) else $error("more than one ack in a cycle");

endmodule

`default_nettype wire

/* mc_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mc_bus_top
    import mc_bus_pkg::*;
    (
        input  wire     clk,
        input  wire     reset,
        input  wb_req_t i_wb_req,
        output wb_rsp_t o_wb_rsp,
        output logic    o_char_valid,
        output char_t   o_char,
        output logic    o_bus_error
    );

    wb_req_t ram_req;
    wb_rsp_t ram_rsp;
    wb_req_t con_req;
    wb_rsp_t con_rsp;

    mc_bus_decoder i_mc_bus_decoder (
        .clk         (clk),
        .reset       (reset),
        .i_req       (i_wb_req),
        .o_rsp       (o_wb_rsp),
        .o_ram_req   (ram_req),
        .i_ram_rsp   (ram_rsp),
        .o_con_req   (con_req),
        .i_con_rsp   (con_rsp),
        .o_bus_error (o_bus_error)
    );

    mc_wb_ram i_mc_wb_ram (
        .clk   (clk),
        .reset (reset),
        .i_req (ram_req),
        .o_rsp (ram_rsp)
    );

    // console at byte 0x0040
    mc_console_port i_mc_console_port (
        .clk          (clk),
        .reset        (reset),
        .i_req        (con_req),
        .o_rsp        (con_rsp),
        .o_char_valid (o_char_valid),
        .o_char       (o_char)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);

    initial begin
        o_clk = 1'b0;
        forever #5 o_clk = ~o_clk;   // 10 ns period
    end

    // reset held low for the first 5 rising edges
    initial begin
        o_reset = 1'b0;
        repeat (5) @(posedge o_clk);
        #1 o_reset = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_mc_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mc_bus
    import mc_bus_pkg::*;
    ();

    logic        clk;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        char_valid;
    char_t       char_out;
    logic        bus_error;
    int          errors = 0;
    int          checks = 0;
    char_t       stream [$];
    wb_dat_t     ram_model [RAM_DEPTH];
    logic        ram_used [RAM_DEPTH];
    string       msg = "hello, mcu";

    tb_clock_gen i_tb_clock_gen (
        .o_clk   (clk),
        .o_reset (reset)
    );

    mc_bus_top i_mc_bus_top (
        .clk          (clk),
        .reset        (reset),
        .i_wb_req     (wb_req),
        .o_wb_rsp     (wb_rsp),
        .o_char_valid (char_valid),
        .o_char       (char_out),
        .o_bus_error  (bus_error)
    );

    always @(negedge clk) begin
        if (reset && char_valid) begin
            stream.push_back(char_out);
        end
    end

    // the tests take well under 5000 cycles of 10 ns
    initial begin
        #200_000;
        $display("timeout, the tests did not finish within 200 us");
        $display("Errors found");
        $finish;
    end

    task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic bus_cycle(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel,
                             input logic we, output wb_dat_t rdat, output logic err,
                             output int lat);
        @(posedge clk);
        #1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        wb_req.we  = we;
        wb_req.stb = 1'b1;
        rdat = '0;
        err  = 1'b0;
        lat  = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!wb_rsp.ack && lat < 10);
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;   // valid in the ack cycle only
            err  = bus_error;
        end else begin
            errors++;
            $display("no ack from word address %h within 10 cycles", adr);
        end
        wb_req.stb = 1'b0;
    endtask

    task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
        wb_dat_t rdat;
        logic    err;
        int      lat;
        bus_cycle(adr, dat, sel, 1'b1, rdat, err, lat);
    endtask

    task automatic bus_read(input wb_adr_t adr, output wb_dat_t rdat);
        logic err;
        int   lat;
        bus_cycle(adr, '0, 4'hf, 1'b0, rdat, err, lat);
    endtask

    function automatic wb_dat_t merge_lanes(input wb_dat_t old, input wb_dat_t dat,
                                            input wb_sel_t sel);
        wb_dat_t res;
        res = old;
        for (int l = 0; l < WB_SEL_W; l++) begin
            if (sel[l]) begin
                res[8*l +: 8] = dat[8*l +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_ram_model(input string name);
        wb_dat_t rdat;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            if (ram_used[i]) begin
                bus_read(RAM_BASE + wb_adr_t'(i), rdat);
                check_word(name, ram_model[i], rdat);
            end
        end
    endtask

    task automatic test_ram_lanes();
        wb_dat_t dat;
        wb_sel_t sel;
        int      idx;
        int      written [$];
        for (int i = 0; i < 64; i++) begin
            idx = $urandom_range(RAM_DEPTH - 1);
            dat = $urandom;
            bus_write(RAM_BASE + wb_adr_t'(idx), dat, 4'hf);
            ram_model[idx] = dat;
            ram_used[idx]  = 1'b1;
            written.push_back(idx);
        end
        for (int i = 0; i < 32; i++) begin
            idx = written[$urandom_range(written.size() - 1)];
            sel = wb_sel_t'(1 << $urandom_range(WB_SEL_W - 1));   // one lane only
            dat = $urandom;
            bus_write(RAM_BASE + wb_adr_t'(idx), dat, sel);
            ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
        end
        check_ram_model("ram_lanes");
    endtask

    task automatic test_console_stream();
        stream.delete();
        for (int i = 0; i < msg.len(); i++) begin
            bus_write(CON_TX_ADR, {24'h0, msg[i]}, 4'h1);
        end
        bus_write(CON_TX_ADR, 32'h0000_0021, 4'he);   // lane 0 off, no pulse
        @(posedge clk);
        check_word("stream_count", 32'(msg.len()), 32'(stream.size()));
        for (int i = 0; i < msg.len(); i++) begin
            check_word($sformatf("stream_char_%0d", i), {24'h0, msg[i]}, {24'h0, stream[i]});
        end
    endtask

    task automatic test_fifo_pop();
        wb_dat_t rdat;
        bus_read(CON_STAT_ADR, rdat);
        check_word("fifo_count", 32'(msg.len()), rdat);
        for (int i = 0; i < msg.len(); i++) begin
            bus_read(CON_POP_ADR, rdat);
            check_word($sformatf("fifo_pop_%0d", i), {23'h0, 1'b1, msg[i]}, rdat);
        end
        bus_read(CON_POP_ADR, rdat);
        check_word("fifo_pop_empty", '0, rdat);
    endtask

    task automatic test_overflow();
        wb_dat_t rdat;
        for (int i = 0; i < 20; i++) begin
            bus_write(CON_TX_ADR, wb_dat_t'(65 + i), 4'h1);
        end
        bus_read(CON_STAT_ADR, rdat);
        check_word("overflow_status", 32'h0000_0110, rdat);   // count 16, overflow
        for (int i = 0; i < CON_FIFO_DEPTH; i++) begin
            bus_read(CON_POP_ADR, rdat);
            check_word($sformatf("overflow_pop_%0d", i), 32'h100 | wb_dat_t'(65 + i), rdat);
        end
        bus_read(CON_STAT_ADR, rdat);
        check_word("overflow_sticky", 32'h0000_0100, rdat);
    endtask

    task automatic test_unmapped();
        wb_dat_t rdat;
        logic    err;
        int      lat;
        bus_write(RAM_BASE, 32'h1357_9bdf, 4'hf);
        ram_model[0] = 32'h1357_9bdf;
        ram_used[0]  = 1'b1;
        bus_cycle(14'h0200, '0, 4'hf, 1'b0, rdat, err, lat);   // byte 0x0800
        check_word("unmapped_read_data", '0, rdat);
        check_word("unmapped_read_error", 32'h1, {31'h0, err});
        bus_cycle(CON_STAT_ADR, 32'hffff_ffff, 4'hf, 1'b1, rdat, err, lat);
        check_word("stat_write_data", '0, rdat);
        check_word("stat_write_error", 32'h1, {31'h0, err});
        bus_cycle(14'h0500, 32'hdead_beef, 4'hf, 1'b1, rdat, err, lat);   // aliases ram index 0
        check_word("unmapped_write_error", 32'h1, {31'h0, err});
        check_ram_model("unmapped_ram_keep");
    endtask

    task automatic test_latency();
        wb_adr_t    adrs [7];
        logic [6:0] wes;
        logic [6:0] errs;
        wb_dat_t    rdat;
        logic       err;
        int         lat;
        adrs = '{RAM_BASE, RAM_BASE, CON_TX_ADR, CON_STAT_ADR, CON_POP_ADR,
                 14'h0200, CON_STAT_ADR};
        wes  = 7'b1000101;
        errs = 7'b1100000;   // last two are unmapped or illegal
        for (int i = 0; i < 7; i++) begin
            bus_cycle(adrs[i], 32'h0000_0058, 4'hf, wes[i], rdat, err, lat);
            check_word($sformatf("latency_%0d", i), 32'h1, 32'(lat));
            check_word($sformatf("latency_error_%0d", i), {31'h0, errs[i]}, {31'h0, err});
        end
    endtask

    initial begin
        void'($urandom(32'he4f2));
        wb_req   = '0;
        ram_used = '{default: 1'b0};
        wait (reset === 1'b1);
        @(posedge clk);
        #1;
        check_word("reset_outputs", '0, {29'h0, wb_rsp.ack, char_valid, bus_error});
        test_ram_lanes();
        test_console_stream();
        test_fifo_pop();
        test_overflow();
        test_unmapped();
        test_latency();
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mc_bus_top.f */
mc_bus_pkg.sv
mc_wb_ram.sv
mc_console_port.sv
mc_bus_decoder.sv
mc_bus_top.sv
tb_clock_gen.sv
tb_mc_bus.sv

/* Makefile */
SRCS = $(shell grep -v '^+' mc_bus_top.f)

obj_dir/Vtb_mc_bus: mc_bus_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mc_bus -f mc_bus_top.f

run: obj_dir/Vtb_mc_bus
	./obj_dir/Vtb_mc_bus | tee sim.log
	@if grep -q "Errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
